// ==== source/cnn_defines.svh ====
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// datapath widths
`define DATA_WIDTH 16
`define ACC_WIDTH 40 // wide enough for k*k*depth products

// lanes computed side by side
`define PARA_KERNEL 2

// configuration limits
`define FM_SIZE_MAX 8
`define DEPTH_MAX 4
`define KERNEL_SIZE_MAX 3

// ram addressing
`define FM_ADDR_WIDTH 8 // FM_SIZE_MAX^2 * DEPTH_MAX words
`define WT_ADDR_WIDTH 6 // KERNEL_SIZE_MAX^2 * DEPTH_MAX words

// configuration fields
`define FM_SIZE_WIDTH 4
`define DEPTH_WIDTH 3
`define KSIZE_WIDTH 2

`define LAYER_NUM_WIDTH 4

`endif

// ==== source/cnn_data_pkg.sv ====
`include "cnn_defines.svh"

package cnn_data_pkg;

	// one feature-map pixel or one weight
	typedef logic signed [`DATA_WIDTH-1:0] pixel_t;

	// one weight per kernel lane, lane 0 in the low bits
	typedef pixel_t [`PARA_KERNEL-1:0] weight_vec_t;

	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

	// finished output pixel for all lanes
	typedef struct packed {
		logic [`FM_SIZE_WIDTH-1:0] row;
		logic [`FM_SIZE_WIDTH-1:0] col;
		acc_t [`PARA_KERNEL-1:0] acc; // acc[l] belongs to kernel l
	} conv_result_t;

endpackage

// ==== source/cnn_ctrl_pkg.sv ====
`include "cnn_defines.svh"

package cnn_ctrl_pkg;

	typedef enum logic [1:0] {
		lt_load = 2'd0, // rams being filled
		lt_conv = 2'd1,
		lt_pool = 2'd2, // not handled here
		lt_fc   = 2'd3  // not handled here
	} layer_type_e;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain, // waiting for the pipeline to empty
		st_done
	} ctrl_state_e;

	// stable for the whole layer
	typedef struct packed {
		logic [`FM_SIZE_WIDTH-1:0] fm_size;
		logic [`DEPTH_WIDTH-1:0] fm_depth;
		logic [`KSIZE_WIDTH-1:0] kernel_size;
	} layer_cfg_t;

	typedef struct packed {
		logic valid;
		logic [`FM_ADDR_WIDTH-1:0] addr;
		cnn_data_pkg::pixel_t data;
	} fm_wr_t;

	typedef struct packed {
		logic valid;
		logic [`WT_ADDR_WIDTH-1:0] addr;
		cnn_data_pkg::weight_vec_t data;
	} wt_wr_t;

	// one kernel tap as seen by the mac lanes
	typedef struct packed {
		logic first; // load instead of accumulate
		logic last;  // pixel complete after this tap
		logic [`FM_SIZE_WIDTH-1:0] out_row;
		logic [`FM_SIZE_WIDTH-1:0] out_col;
		logic valid;
	} tap_t;

endpackage

// ==== source/layer_ctrl_fsm.sv ====
`timescale 1ns/1ps

`include "cnn_defines.svh"

module layer_ctrl_fsm (
	input  logic clk,
	input  logic rst,
	input  cnn_ctrl_pkg::layer_type_e layer_type_i,
	input  logic [`LAYER_NUM_WIDTH-1:0] layer_num_i,
	input  logic init_fm_done_i,
	input  logic init_weight_done_i,
	input  logic walk_done_i,
	output logic init_fm_ready_o,
	output logic init_weight_ready_o,
	output logic run_o,
	output logic layer_ready_o
);

	cnn_ctrl_pkg::ctrl_state_e state_q;
	logic [`LAYER_NUM_WIDTH-1:0] layer_num_q; // number of the last layer started
	logic drain_cnt_q;
	logic can_start;
	logic start;

	// a new layer may only begin once the previous one has fully drained
	assign can_start = (state_q == cnn_ctrl_pkg::st_idle) ||
		(state_q == cnn_ctrl_pkg::st_done);

	assign start = can_start &&
		(layer_type_i == cnn_ctrl_pkg::lt_conv) &&
		(layer_num_i != layer_num_q) &&
		init_fm_ready_o && init_weight_ready_o;

	// readiness only tracks the done levels during loading
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			init_fm_ready_o     <= 1'b0;
			init_weight_ready_o <= 1'b0;
		end else if (layer_type_i == cnn_ctrl_pkg::lt_load) begin
			init_fm_ready_o     <= init_fm_done_i;
			init_weight_ready_o <= init_weight_done_i;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q     <= cnn_ctrl_pkg::st_idle;
			layer_num_q <= '0;
			drain_cnt_q <= 1'b0;
		end else begin
			case (state_q)
				cnn_ctrl_pkg::st_idle,
				cnn_ctrl_pkg::st_done: begin
					if (start) begin
						state_q     <= cnn_ctrl_pkg::st_run;
						layer_num_q <= layer_num_i; // latch so the same number does not retrigger
					end
				end
				cnn_ctrl_pkg::st_run: begin
					if (walk_done_i) begin
						state_q     <= cnn_ctrl_pkg::st_drain;
						drain_cnt_q <= 1'b0;
					end
				end
				cnn_ctrl_pkg::st_drain: begin
					// ram read cycle, then the result register
					if (drain_cnt_q) begin
						state_q <= cnn_ctrl_pkg::st_done;
					end else begin
						drain_cnt_q <= 1'b1;
					end
				end
				default: state_q <= cnn_ctrl_pkg::st_idle;
			endcase
		end
	end

	assign run_o         = (state_q == cnn_ctrl_pkg::st_run);
	assign layer_ready_o = (state_q == cnn_ctrl_pkg::st_done); // drops as soon as a new start is taken

endmodule

// ==== source/conv_window_counter.sv ====
`timescale 1ns/1ps

`include "cnn_defines.svh"

module conv_window_counter (
	input  logic clk,
	input  logic rst,
	input  logic run_i,
	input  cnn_ctrl_pkg::layer_cfg_t cfg_i,
	output logic [`FM_ADDR_WIDTH-1:0] fm_raddr_o,
	output logic [`WT_ADDR_WIDTH-1:0] wt_raddr_o,
	output cnn_ctrl_pkg::tap_t tap_o,
	output logic walk_done_o
);

	logic [`KSIZE_WIDTH-1:0] kx_q;
	logic [`KSIZE_WIDTH-1:0] ky_q;
	logic [`DEPTH_WIDTH-1:0] slice_q;
	logic [`FM_SIZE_WIDTH-1:0] col_q;
	logic [`FM_SIZE_WIDTH-1:0] row_q;

	logic [`FM_SIZE_WIDTH-1:0] out_last; // last output index, fm_size - k
	logic last_kx;
	logic last_ky;
	logic last_slice;
	logic last_col;
	logic last_row;
	logic first_tap;
	logic last_tap;

	logic [`FM_SIZE_WIDTH-1:0] in_row; // input pixel under the current tap
	logic [`FM_SIZE_WIDTH-1:0] in_col;
	logic [`FM_ADDR_WIDTH-1:0] plane_size;
	logic [`WT_ADDR_WIDTH-1:0] k_sq;

	assign out_last   = cfg_i.fm_size - `FM_SIZE_WIDTH'(cfg_i.kernel_size);
	assign last_kx    = (kx_q == cfg_i.kernel_size - `KSIZE_WIDTH'(1));
	assign last_ky    = (ky_q == cfg_i.kernel_size - `KSIZE_WIDTH'(1));
	assign last_slice = (slice_q == cfg_i.fm_depth - `DEPTH_WIDTH'(1));
	assign last_col   = (col_q == out_last);
	assign last_row   = (row_q == out_last);

	assign first_tap = (kx_q == '0) && (ky_q == '0) && (slice_q == '0);
	assign last_tap  = last_kx && last_ky && last_slice;

	// slice * n*n + (row+ky) * n + (col+kx)
	assign in_row     = row_q + `FM_SIZE_WIDTH'(ky_q);
	assign in_col     = col_q + `FM_SIZE_WIDTH'(kx_q);
	assign plane_size = `FM_ADDR_WIDTH'(cfg_i.fm_size) * `FM_ADDR_WIDTH'(cfg_i.fm_size);
	assign fm_raddr_o = `FM_ADDR_WIDTH'(slice_q) * plane_size +
		`FM_ADDR_WIDTH'(in_row) * `FM_ADDR_WIDTH'(cfg_i.fm_size) +
		`FM_ADDR_WIDTH'(in_col);

	// slice * k*k + ky * k + kx
	assign k_sq       = `WT_ADDR_WIDTH'(cfg_i.kernel_size) * `WT_ADDR_WIDTH'(cfg_i.kernel_size);
	assign wt_raddr_o = `WT_ADDR_WIDTH'(slice_q) * k_sq +
		`WT_ADDR_WIDTH'(ky_q) * `WT_ADDR_WIDTH'(cfg_i.kernel_size) +
		`WT_ADDR_WIDTH'(kx_q);

	always_comb begin
		tap_o.valid   = run_i;
		tap_o.first   = first_tap;
		tap_o.last    = last_tap;
		tap_o.out_row = row_q;
		tap_o.out_col = col_q;
	end

	assign walk_done_o = run_i && last_tap && last_col && last_row;

	// kx innermost, then ky, slice, column, row
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			kx_q    <= '0;
			ky_q    <= '0;
			slice_q <= '0;
			col_q   <= '0;
			row_q   <= '0;
		end else if (!run_i) begin // park at the origin between layers
			kx_q    <= '0;
			ky_q    <= '0;
			slice_q <= '0;
			col_q   <= '0;
			row_q   <= '0;
		end else begin
			kx_q <= last_kx ? '0 : kx_q + 1'b1;
			if (last_kx) begin
				ky_q <= last_ky ? '0 : ky_q + 1'b1;
				if (last_ky) begin
					slice_q <= last_slice ? '0 : slice_q + 1'b1;
					if (last_slice) begin
						col_q <= last_col ? '0 : col_q + 1'b1;
						if (last_col) begin
							row_q <= last_row ? '0 : row_q + 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

// ==== source/sp_ram.sv ====
`timescale 1ns/1ps

module sp_ram #(
	parameter type word_t = logic [15:0],
	parameter int  DEPTH  = 16
) (
	input  logic clk,
	input  logic we_i,
	input  logic [$clog2(DEPTH)-1:0] waddr_i,
	input  word_t wdata_i,
	input  logic [$clog2(DEPTH)-1:0] raddr_i,
	output word_t rdata_o
);

	word_t mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

// ==== source/conv_mac_array.sv ====
`timescale 1ns/1ps

`include "cnn_defines.svh"

module conv_mac_array (
	input  logic clk,
	input  logic rst,
	input  cnn_ctrl_pkg::tap_t tap_i, // already aligned with the ram data
	input  cnn_data_pkg::pixel_t pixel_i,
	input  cnn_data_pkg::weight_vec_t weights_i,
	output logic result_valid_o,
	output cnn_data_pkg::conv_result_t result_o
);

	cnn_data_pkg::acc_t [`PARA_KERNEL-1:0] acc_q;
	cnn_data_pkg::acc_t [`PARA_KERNEL-1:0] acc_d;

	// one lane per kernel, all share the pixel
	always_comb begin
		cnn_data_pkg::acc_t prod;

		for (int l = 0; l < `PARA_KERNEL; l++) begin
			prod = pixel_i * $signed(weights_i[l]); // sign extended to full width
			acc_d[l] = tap_i.first ? prod : acc_q[l] + prod;
		end
	end

	always_ff @(posedge clk) begin
		if (tap_i.valid) begin
			acc_q <= acc_d;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= tap_i.valid && tap_i.last;
		end
	end

	// capture the finished sums so the next pixel can start right away
	always_ff @(posedge clk) begin
		if (tap_i.valid && tap_i.last) begin
			result_o.row <= tap_i.out_row;
			result_o.col <= tap_i.out_col;
			result_o.acc <= acc_d;
		end
	end

endmodule

// ==== source/conv_layer_top.sv ====
`timescale 1ns/1ps

`include "cnn_defines.svh"

module conv_layer_top (
	input  logic clk,
	input  logic rst,
	input  cnn_ctrl_pkg::layer_type_e layer_type_i,
	input  logic [`LAYER_NUM_WIDTH-1:0] layer_num_i,
	input  cnn_ctrl_pkg::layer_cfg_t cfg_i,
	input  cnn_ctrl_pkg::fm_wr_t fm_wr_i,
	input  cnn_ctrl_pkg::wt_wr_t wt_wr_i,
	input  logic init_fm_done_i,
	input  logic init_weight_done_i,
	output logic init_fm_ready_o,
	output logic init_weight_ready_o,
	output logic layer_ready_o,
	output logic result_valid_o,
	output cnn_data_pkg::conv_result_t result_o
);

	logic run;
	logic walk_done;
	logic loading;
	logic fm_we;
	logic wt_we;
	logic [`FM_ADDR_WIDTH-1:0] fm_raddr;
	logic [`WT_ADDR_WIDTH-1:0] wt_raddr;
	cnn_ctrl_pkg::tap_t tap;
	cnn_ctrl_pkg::tap_t tap_q; // follows the ram read by one cycle
	cnn_data_pkg::pixel_t pixel;
	cnn_data_pkg::weight_vec_t weights;

	// rams are only written while loading
	assign loading = (layer_type_i == cnn_ctrl_pkg::lt_load);
	assign fm_we   = fm_wr_i.valid && loading;
	assign wt_we   = wt_wr_i.valid && loading;

	layer_ctrl_fsm ctrl_fsm_i (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type_i),
		.layer_num_i         (layer_num_i),
		.init_fm_done_i      (init_fm_done_i),
		.init_weight_done_i  (init_weight_done_i),
		.walk_done_i         (walk_done),
		.init_fm_ready_o     (init_fm_ready_o),
		.init_weight_ready_o (init_weight_ready_o),
		.run_o               (run),
		.layer_ready_o       (layer_ready_o)
	);

	conv_window_counter win_cnt_i (
		.clk         (clk),
		.rst         (rst),
		.run_i       (run),
		.cfg_i       (cfg_i),
		.fm_raddr_o  (fm_raddr),
		.wt_raddr_o  (wt_raddr),
		.tap_o       (tap),
		.walk_done_o (walk_done)
	);

	sp_ram #(
		.word_t (cnn_data_pkg::pixel_t),
		.DEPTH  (`FM_SIZE_MAX * `FM_SIZE_MAX * `DEPTH_MAX)
	) fm_ram_i (
		.clk     (clk),
		.we_i    (fm_we),
		.waddr_i (fm_wr_i.addr),
		.wdata_i (fm_wr_i.data),
		.raddr_i (fm_raddr),
		.rdata_o (pixel)
	);

	sp_ram #(
		.word_t (cnn_data_pkg::weight_vec_t),
		.DEPTH  (`KERNEL_SIZE_MAX * `KERNEL_SIZE_MAX * `DEPTH_MAX)
	) wt_ram_i (
		.clk     (clk),
		.we_i    (wt_we),
		.waddr_i (wt_wr_i.addr),
		.wdata_i (wt_wr_i.data),
		.raddr_i (wt_raddr),
		.rdata_o (weights)
	);

	// match the ram read latency
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_q <= '0;
		end else begin
			tap_q <= tap;
		end
	end

	conv_mac_array mac_i (
		.clk            (clk),
		.rst            (rst),
		.tap_i          (tap_q),
		.pixel_i        (pixel),
		.weights_i      (weights),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

endmodule

// ==== dv/conv_layer_props.sv ====
`timescale 1ns/1ps

module conv_layer_props (
	input logic clk,
	input logic rst,
	input cnn_ctrl_pkg::layer_type_e layer_type_i,
	input logic fm_done_i,
	input logic wt_done_i,
	input logic fm_ready_i,
	input logic wt_ready_i,
	input logic layer_ready_i,
	input logic result_valid_i
);

	int unsigned fail_cnt = 0;

	// results only stream while a layer is in progress
	no_result_when_ready: assert property (@(posedge clk) disable iff (!rst)
		!(result_valid_i && layer_ready_i))
	else begin
		$error("result_valid_o high while layer_ready_o is high");
		fail_cnt++;
	end

	quiet_in_reset: assert property (@(posedge clk)
		!rst |-> !(fm_ready_i || wt_ready_i || layer_ready_i || result_valid_i))
	else begin
		$error("an output is high during reset");
		fail_cnt++;
	end

	fm_ready_follows: assert property (@(posedge clk) disable iff (!rst)
		(layer_type_i == cnn_ctrl_pkg::lt_load) |=> (fm_ready_i == $past(fm_done_i)))
	else begin
		$error("init_fm_ready_o did not follow init_fm_done_i");
		fail_cnt++;
	end

	wt_ready_follows: assert property (@(posedge clk) disable iff (!rst)
		(layer_type_i == cnn_ctrl_pkg::lt_load) |=> (wt_ready_i == $past(wt_done_i)))
	else begin
		$error("init_weight_ready_o did not follow init_weight_done_i");
		fail_cnt++;
	end

endmodule

bind conv_layer_top conv_layer_props props_i (
	.clk            (clk),
	.rst            (rst),
	.layer_type_i   (layer_type_i),
	.fm_done_i      (init_fm_done_i),
	.wt_done_i      (init_weight_done_i),
	.fm_ready_i     (init_fm_ready_o),
	.wt_ready_i     (init_weight_ready_o),
	.layer_ready_i  (layer_ready_o),
	.result_valid_i (result_valid_o)
);

// ==== dv/conv_layer_tb.sv ====
`timescale 1ns/1ps

`include "cnn_defines.svh"

module conv_layer_tb;

	logic clk = 1'b0;
	logic rst;
	cnn_ctrl_pkg::layer_type_e layer_type;
	logic [`LAYER_NUM_WIDTH-1:0] layer_num;
	cnn_ctrl_pkg::layer_cfg_t cfg;
	cnn_ctrl_pkg::fm_wr_t fm_wr;
	cnn_ctrl_pkg::wt_wr_t wt_wr;
	logic init_fm_done;
	logic init_weight_done;
	logic init_fm_ready;
	logic init_weight_ready;
	logic layer_ready;
	logic result_valid;
	cnn_data_pkg::conv_result_t result;

	// ram contents as [slice][row][col] and [slice][ky][kx]
	cnn_data_pkg::pixel_t pix [`DEPTH_MAX][`FM_SIZE_MAX][`FM_SIZE_MAX];
	cnn_data_pkg::weight_vec_t wts [`DEPTH_MAX][`KERNEL_SIZE_MAX][`KERNEL_SIZE_MAX];
	cnn_data_pkg::conv_result_t exp_q [$]; // results still to come, row-major
	cnn_data_pkg::conv_result_t exp_res;
	logic [`LAYER_NUM_WIDTH-1:0] layer_id = '0;
	int result_cnt = 0;
	int check_cnt = 0;
	int err_cnt = 0;
	int test_cnt = 0;
	int test_err_base = 0;
	int cycle_cnt = 0;

	// taps of one layer plus its ram loading
	function automatic int test_cycles(input int n, input int d, input int k);
		return (n - k + 1) * (n - k + 1) * k * k * d + 20 + n * n * d + k * k * d;
	endfunction

	localparam int TIMEOUT_CYCLES = 2 * (40 + test_cycles(5, 2, 3) + test_cycles(4, 1, 1) +
		2 * test_cycles(8, 4, 2));

	conv_layer_top dut_i (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type),
		.layer_num_i         (layer_num),
		.cfg_i               (cfg),
		.fm_wr_i             (fm_wr),
		.wt_wr_i             (wt_wr),
		.init_fm_done_i      (init_fm_done),
		.init_weight_done_i  (init_weight_done),
		.init_fm_ready_o     (init_fm_ready),
		.init_weight_ready_o (init_weight_ready),
		.layer_ready_o       (layer_ready),
		.result_valid_o      (result_valid),
		.result_o            (result)
	);

	always #5 clk = ~clk;

	function automatic int total_errors();
		return err_cnt + int'(dut_i.props_i.fail_cnt);
	endfunction

	task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] want);
		check_cnt++;
		assert (got === want) else begin
			$display("** Error %s: got %h, expected %h", name, got, want);
			err_cnt++;
		end
	endtask

	task automatic expect_true(input logic cond, input string msg);
		check_cnt++;
		assert (cond) else begin
			$display("failure: %s", msg);
			err_cnt++;
		end
	endtask

	task automatic close_test(input string name);
		test_cnt++;
		$display("test %0d %s finished, %0d errors", test_cnt, name,
			total_errors() - test_err_base);
		test_err_base = total_errors();
	endtask

	task automatic load_rams(input int n, input int d, input int k);
		@(posedge clk);
		layer_type <= cnn_ctrl_pkg::lt_load;
		init_fm_done <= 1'b0;
		init_weight_done <= 1'b0;
		for (int s = 0; s < d; s++) begin
			for (int y = 0; y < n; y++) begin
				for (int x = 0; x < n; x++) begin
					pix[s][y][x] = cnn_data_pkg::pixel_t'($urandom);
					@(posedge clk);
					fm_wr <= '{valid: 1'b1, addr: `FM_ADDR_WIDTH'(s * n * n + y * n + x),
						data: pix[s][y][x]};
				end
			end
		end
		for (int s = 0; s < d; s++) begin
			for (int ky = 0; ky < k; ky++) begin
				for (int kx = 0; kx < k; kx++) begin
					for (int l = 0; l < `PARA_KERNEL; l++) begin
						wts[s][ky][kx][l] = cnn_data_pkg::pixel_t'($urandom);
					end
					@(posedge clk);
					fm_wr <= '0;
					wt_wr <= '{valid: 1'b1, addr: `WT_ADDR_WIDTH'(s * k * k + ky * k + kx),
						data: wts[s][ky][kx]};
				end
			end
		end
		@(posedge clk);
		wt_wr <= '0;
		init_fm_done <= 1'b1;
		init_weight_done <= 1'b1;
		@(posedge clk);
		while (!(init_fm_ready && init_weight_ready)) begin
			@(posedge clk);
		end
	endtask

	// full precision sum over slice, ky and kx for each lane
	function automatic void build_expected(input int n, input int d, input int k);
		cnn_data_pkg::conv_result_t r;
		cnn_data_pkg::acc_t sum;

		exp_q.delete();
		for (int row = 0; row <= n - k; row++) begin
			for (int col = 0; col <= n - k; col++) begin
				r.row = `FM_SIZE_WIDTH'(row);
				r.col = `FM_SIZE_WIDTH'(col);
				for (int l = 0; l < `PARA_KERNEL; l++) begin
					sum = '0;
					for (int s = 0; s < d; s++) begin
						for (int ky = 0; ky < k; ky++) begin
							for (int kx = 0; kx < k; kx++) begin
								sum = sum + cnn_data_pkg::acc_t'(pix[s][row + ky][col + kx]) *
									cnn_data_pkg::acc_t'($signed(wts[s][ky][kx][l]));
							end
						end
					end
					r.acc[l] = sum;
				end
				exp_q.push_back(r);
			end
		end
	endfunction

	task automatic run_layer(input int n, input int d, input int k);
		@(posedge clk);
		cfg <= '{fm_size: `FM_SIZE_WIDTH'(n), fm_depth: `DEPTH_WIDTH'(d),
			kernel_size: `KSIZE_WIDTH'(k)};
		layer_type <= cnn_ctrl_pkg::lt_conv;
		layer_id = layer_id + 1'b1;
		layer_num <= layer_id;
		result_cnt = 0;
		repeat (2) @(posedge clk);
		compare_hex("layer_ready_o", 64'(layer_ready), 64'(0)); // low from the start cycle
		while (!layer_ready) begin
			@(posedge clk);
		end
		compare_hex("result count", 64'(result_cnt), 64'((n - k + 1) * (n - k + 1)));
		expect_true(exp_q.size() == 0, "layer ended with expected results still missing");
	endtask

	// outputs are sampled half a cycle after the edge that sets them
	always @(negedge clk) begin
		if (rst && result_valid) begin
			result_cnt++;
			if (exp_q.size() == 0) begin
				expect_true(1'b0, "result_valid_o pulsed with no result outstanding");
			end else begin
				exp_res = exp_q.pop_front();
				compare_hex("result_o.row", 64'(result.row), 64'(exp_res.row));
				compare_hex("result_o.col", 64'(result.col), 64'(exp_res.col));
				for (int l = 0; l < `PARA_KERNEL; l++) begin
					compare_hex($sformatf("result_o.acc[%0d]", l), 64'(result.acc[l]),
						64'(exp_res.acc[l]));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT never finished its layer", cycle_cnt);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h39a7));
		rst = 1'b0;
		layer_type = cnn_ctrl_pkg::lt_load;
		layer_num = '0;
		cfg = '0;
		fm_wr = '0;
		wt_wr = '0;
		init_fm_done = 1'b0;
		init_weight_done = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		expect_true(!(layer_ready || result_valid || init_fm_ready || init_weight_ready),
			"outputs not all low after reset");
		close_test("after reset");

		init_fm_done <= 1'b1; // weights stay not done
		repeat (2) @(posedge clk);
		compare_hex("init_fm_ready_o", 64'(init_fm_ready), 64'(1));
		compare_hex("init_weight_ready_o", 64'(init_weight_ready), 64'(0));
		layer_id = 1;
		layer_num <= layer_id;
		layer_type <= cnn_ctrl_pkg::lt_conv;
		// one tap per pixel, so a wrong start would stream results at once
		cfg <= '{fm_size: `FM_SIZE_WIDTH'(4), fm_depth: `DEPTH_WIDTH'(1),
			kernel_size: `KSIZE_WIDTH'(1)};
		repeat (12) @(posedge clk);
		compare_hex("layer_ready_o", 64'(layer_ready), 64'(0));
		close_test("readiness");

		load_rams(5, 2, 3);
		build_expected(5, 2, 3);
		run_layer(5, 2, 3);
		close_test("conv 5x5 depth 2 k 3");

		load_rams(4, 1, 1);
		build_expected(4, 1, 1);
		run_layer(4, 1, 1);
		load_rams(8, 4, 2);
		build_expected(8, 4, 2);
		run_layer(8, 4, 2);
		close_test("conv k 1 and k 2");

		repeat (10) begin
			@(posedge clk);
			expect_true(layer_ready, "layer_ready_o dropped with the layer number unchanged");
		end
		fm_wr <= '{valid: 1'b1, addr: '0, data: ~pix[0][0][0]}; // conv type, must be ignored
		@(posedge clk);
		fm_wr <= '0;
		build_expected(8, 4, 2);
		run_layer(8, 4, 2);
		close_test("layer control");

		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, total_errors());
		if (total_errors() == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== conv_layer.f ====
+incdir+source
source/cnn_data_pkg.sv
source/cnn_ctrl_pkg.sv
source/layer_ctrl_fsm.sv
source/conv_window_counter.sv
source/sp_ram.sv
source/conv_mac_array.sv
source/conv_layer_top.sv
dv/conv_layer_props.sv
dv/conv_layer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= conv_layer_tb
FILELIST  ?= conv_layer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) source/cnn_defines.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
